// ==== ex_pkg.sv ====
// Shared types for the execute stage; xlen is fixed at 32 and the op codes are local to EX
package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Integer data path width
  localparam int unsigned xlen = 32;

  // Divider step counter, wide enough to hold xlen
  localparam int unsigned div_cnt_w = 6;

  // One quotient bit per step
  localparam logic [div_cnt_w-1:0] div_steps = div_cnt_w'(xlen);

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Functional unit that runs the instruction
  typedef enum logic [1:0] {
    unit_alu = 2'd0,
    unit_mul = 2'd1,
    unit_div = 2'd2
  } ex_unit_e;

  // Single-cycle ALU operations
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9
  } alu_op_e;

  // M extension operations, numbered as funct3
  typedef enum logic [3:0] {
    md_mul    = 4'd0,
    md_mulh   = 4'd1,
    md_mulhsu = 4'd2,
    md_mulhu  = 4'd3,
    md_div    = 4'd4,
    md_divu   = 4'd5,
    md_rem    = 4'd6,
    md_remu   = 4'd7
  } md_op_e;

  // Same op field, read through the view that matches the unit select
  typedef union packed {
    alu_op_e alu;
    md_op_e  md;
  } ex_op_u;

  //////////////////////////////////////////////////////////////////////
  // Pipeline words
  //////////////////////////////////////////////////////////////////////

  // Decode to EX
  typedef struct packed {
    logic            valid;
    ex_unit_e        unit;
    ex_op_u          op;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      rd;
    logic            rf_we;
  } id_ex_t;

  // EX to write-back
  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic            rf_we;
    logic [xlen-1:0] wdata;
  } ex_wb_t;

endpackage

// ==== ex_alu.sv ====
// Purely combinational; shifts take only the low log2(xlen) bits of b_i, unknown ops give zero
`timescale 1ns/100ps

module ex_alu (
  input  ex_pkg::alu_op_e         op_i,
  input  logic [ex_pkg::xlen-1:0] a_i,
  input  logic [ex_pkg::xlen-1:0] b_i,
  output logic [ex_pkg::xlen-1:0] result_o
);

  // Shift amount
  logic [$clog2(ex_pkg::xlen)-1:0] shamt;

  // Compare flags
  logic lt_signed;
  logic lt_unsigned;

  assign shamt = b_i[$clog2(ex_pkg::xlen)-1:0];

  // Signed compare reinterprets both operands
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  //////////////////////////////////////////////////////////////////////
  // Operation select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      // Arithmetic
      ex_pkg::alu_add: result_o = a_i + b_i;
      ex_pkg::alu_sub: result_o = a_i - b_i;

      // Bitwise logic
      ex_pkg::alu_and: result_o = a_i & b_i;
      ex_pkg::alu_or:  result_o = a_i | b_i;
      ex_pkg::alu_xor: result_o = a_i ^ b_i;

      // Shifts
      ex_pkg::alu_sll: result_o = a_i << shamt;
      ex_pkg::alu_srl: result_o = a_i >> shamt;
      // Arithmetic right shift replicates the sign bit
      ex_pkg::alu_sra: result_o = $unsigned($signed(a_i) >>> shamt);

      // Set-less-than, flag in bit 0
      ex_pkg::alu_slt:  result_o = {{(ex_pkg::xlen-1){1'b0}}, lt_signed};
      ex_pkg::alu_sltu: result_o = {{(ex_pkg::xlen-1){1'b0}}, lt_unsigned};

      // Unused encodings
      default: result_o = '0;
    endcase
  end

endmodule

// ==== ex_mult.sv ====
// One product in flight; op_i must stay stable from start_i until the result is accepted
`timescale 1ns/100ps

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start_i,
  input  ex_pkg::md_op_e          op_i,
  input  logic [ex_pkg::xlen-1:0] a_i,
  input  logic [ex_pkg::xlen-1:0] b_i,
  input  logic                    accept_i,
  output logic                    done_o,
  output logic [ex_pkg::xlen-1:0] result_o
);

  // Operand signedness per operation
  logic sign_a;
  logic sign_b;

  // 33-bit operands cover signed and unsigned alike
  logic signed [ex_pkg::xlen:0]     a_ext;
  logic signed [ex_pkg::xlen:0]     b_ext;
  logic signed [2*ex_pkg::xlen+1:0] prod_full;

  // Held product and its valid flag
  logic [2*ex_pkg::xlen-1:0] prod_q;
  logic                      busy_q;

  always_comb begin
    case (op_i)
      ex_pkg::md_mulh: begin
        sign_a = 1'b1;
        sign_b = 1'b1;
      end
      ex_pkg::md_mulhsu: begin
        sign_a = 1'b1;
        sign_b = 1'b0;
      end
      // mul low half is the same either way, mulhu is unsigned
      default: begin
        sign_a = 1'b0;
        sign_b = 1'b0;
      end
    endcase
  end

  assign a_ext = $signed({sign_a & a_i[ex_pkg::xlen-1], a_i});
  assign b_ext = $signed({sign_b & b_i[ex_pkg::xlen-1], b_i});

  // Sign-extend to the full product width before multiplying
  assign prod_full = (2*ex_pkg::xlen+2)'(a_ext) * (2*ex_pkg::xlen+2)'(b_ext);

  // Busy from the edge after start until WB takes the result
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (!busy_q && start_i) begin
      busy_q <= 1'b1;
    end else if (busy_q && accept_i) begin
      busy_q <= 1'b0;
    end
  end

  // Product is captured once and held under back-pressure
  always_ff @(posedge clk) begin
    if (!busy_q && start_i) begin
      prod_q <= prod_full[2*ex_pkg::xlen-1:0];
    end
  end

  assign done_o = busy_q;

  // Low half for mul, high half for the mulh variants
  assign result_o = (op_i == ex_pkg::md_mul) ? prod_q[ex_pkg::xlen-1:0]
                                             : prod_q[2*ex_pkg::xlen-1:ex_pkg::xlen];

endmodule

// ==== div_ctrl_fsm.sv ====
// One division at a time; div_by_zero_i must reflect the divisor captured by load_o
`timescale 1ns/100ps

module div_ctrl_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic start_i,
  input  logic div_by_zero_i,
  input  logic accept_i,
  output logic load_o,
  output logic step_o,
  output logic done_o
);

  // Divider control states
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_busy = 2'd1,
    st_done = 2'd2
  } state_e;

  state_e state_q;
  state_e state_d;

  // Remaining shift-subtract steps
  logic [ex_pkg::div_cnt_w-1:0] cnt_q;
  logic [ex_pkg::div_cnt_w-1:0] cnt_d;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    load_o  = 1'b0;
    step_o  = 1'b0;
    case (state_q)
      st_idle: begin
        // Capture operands in the same cycle the instruction shows up
        if (start_i) begin
          load_o  = 1'b1;
          cnt_d   = ex_pkg::div_steps;
          state_d = st_busy;
        end
      end
      st_busy: begin
        // Zero divisor needs no steps, the datapath forces the result
        if (div_by_zero_i) begin
          state_d = st_done;
        end else begin
          step_o = 1'b1;
          cnt_d  = cnt_q - 1'b1;
          if (cnt_d == '0) begin
            state_d = st_done;
          end
        end
      end
      st_done: begin
        // Result stays valid until WB takes it
        if (accept_i) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  assign done_o = (state_q == st_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= st_idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

// ==== div_datapath.sv ====
// Restoring divider on magnitudes; op_i must stay stable from load until the result is accepted
`timescale 1ns/100ps

module div_datapath (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load_i,
  input  logic                    step_i,
  input  ex_pkg::md_op_e          op_i,
  input  logic [ex_pkg::xlen-1:0] a_i,
  input  logic [ex_pkg::xlen-1:0] b_i,
  output logic                    div_by_zero_o,
  output logic [ex_pkg::xlen-1:0] result_o
);

  // Operation decode
  logic signed_op;
  logic is_rem;

  // Operand magnitudes at load
  logic [ex_pkg::xlen-1:0] mag_a;
  logic [ex_pkg::xlen-1:0] mag_b;

  // Partial remainder, dividend/quotient shift register and divisor
  logic [ex_pkg::xlen-1:0] rem_q;
  logic [ex_pkg::xlen-1:0] quo_q;
  logic [ex_pkg::xlen-1:0] dvs_q;

  // Result signs
  logic neg_quo_q;
  logic neg_rem_q;

  // One step
  logic [ex_pkg::xlen:0] rem_shift;
  logic [ex_pkg::xlen:0] rem_sub;
  logic                  rem_ge;

  // Fix-up
  logic [ex_pkg::xlen-1:0] quo_res;
  logic [ex_pkg::xlen-1:0] rem_src;
  logic [ex_pkg::xlen-1:0] rem_res;

  assign signed_op = (op_i == ex_pkg::md_div) || (op_i == ex_pkg::md_rem);
  assign is_rem    = (op_i == ex_pkg::md_rem) || (op_i == ex_pkg::md_remu);

  assign mag_a = (signed_op && a_i[ex_pkg::xlen-1]) ? (~a_i + 1'b1) : a_i;
  assign mag_b = (signed_op && b_i[ex_pkg::xlen-1]) ? (~b_i + 1'b1) : b_i;

  //////////////////////////////////////////////////////////////////////
  // Shift-subtract
  //////////////////////////////////////////////////////////////////////

  // Next dividend bit enters the remainder from the quotient register top
  assign rem_shift = {rem_q, quo_q[ex_pkg::xlen-1]};
  assign rem_ge    = rem_shift >= {1'b0, dvs_q};
  assign rem_sub   = rem_shift - {1'b0, dvs_q};

  always_ff @(posedge clk) begin
    if (load_i) begin
      rem_q <= '0;
      quo_q <= mag_a;
      dvs_q <= mag_b;
    end else if (step_i) begin
      // Restore by keeping the shifted value when the subtraction would go negative
      rem_q <= rem_ge ? rem_sub[ex_pkg::xlen-1:0] : rem_shift[ex_pkg::xlen-1:0];
      quo_q <= {quo_q[ex_pkg::xlen-2:0], rem_ge};
    end
  end

  // Quotient sign from both operands, remainder follows the dividend
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      neg_quo_q <= 1'b0;
      neg_rem_q <= 1'b0;
    end else if (load_i) begin
      neg_quo_q <= signed_op && (a_i[ex_pkg::xlen-1] ^ b_i[ex_pkg::xlen-1]);
      neg_rem_q <= signed_op && a_i[ex_pkg::xlen-1];
    end
  end

  assign div_by_zero_o = (dvs_q == '0);

  //////////////////////////////////////////////////////////////////////
  // Sign fix-up
  //////////////////////////////////////////////////////////////////////

  // Zero divisor: quotient all ones
  assign quo_res = div_by_zero_o ? '1 : (neg_quo_q ? (~quo_q + 1'b1) : quo_q);

  // Steps were skipped, so quo_q still holds |a| and the sign restores the dividend
  assign rem_src = div_by_zero_o ? quo_q : rem_q;
  assign rem_res = neg_rem_q ? (~rem_src + 1'b1) : rem_src;

  // Most negative / -1 lands on the dividend and zero without a special case
  assign result_o = is_rem ? rem_res : quo_res;

endmodule

// ==== ex_wb_reg.sv ====
// Result must be ready while finish_i is high; unit codes other than mul and div write the ALU result
`timescale 1ns/100ps

module ex_wb_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::id_ex_t          id_ex_i,
  input  logic                    finish_i,
  input  logic                    wb_ready_i,
  input  logic [ex_pkg::xlen-1:0] alu_result_i,
  input  logic [ex_pkg::xlen-1:0] mul_result_i,
  input  logic [ex_pkg::xlen-1:0] div_result_i,
  output ex_pkg::ex_wb_t          ex_wb_o
);

  // Write data from the unit that ran the instruction
  logic [ex_pkg::xlen-1:0] wdata_sel;

  // Register contents
  logic                    valid_q;
  logic                    rf_we_q;
  logic [4:0]              rd_q;
  logic [ex_pkg::xlen-1:0] wdata_q;

  always_comb begin
    case (id_ex_i.unit)
      ex_pkg::unit_mul: wdata_sel = mul_result_i;
      ex_pkg::unit_div: wdata_sel = div_result_i;
      default:          wdata_sel = alu_result_i;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  // Finished instruction or bubble whenever WB is ready, hold otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      rf_we_q <= 1'b0;
    end else if (wb_ready_i) begin
      valid_q <= finish_i;
      rf_we_q <= finish_i && id_ex_i.rf_we;
    end
  end

  // Bubbles leave rd and data as they were
  always_ff @(posedge clk) begin
    if (finish_i && wb_ready_i) begin
      rd_q    <= id_ex_i.rd;
      wdata_q <= wdata_sel;
    end
  end

  assign ex_wb_o = '{valid: valid_q, rd: rd_q, rf_we: rf_we_q, wdata: wdata_q};

endmodule

// ==== ex_stage.sv ====
// Decode must hold id_ex_i while valid and ex_ready_o is low; one instruction is in EX at a time
`timescale 1ns/100ps

module ex_stage (
  input  logic           clk,
  input  logic           rst_n,
  input  ex_pkg::id_ex_t id_ex_i,
  input  logic           wb_ready_i,
  output logic           ex_ready_o,
  output ex_pkg::ex_wb_t ex_wb_o
);

  // Op field seen as an M extension op
  ex_pkg::md_op_e md_op;

  // Unit results
  logic [ex_pkg::xlen-1:0] alu_result;
  logic [ex_pkg::xlen-1:0] mul_result;
  logic [ex_pkg::xlen-1:0] div_result;

  // Unit handshakes
  logic mul_start;
  logic mul_done;
  logic div_start;
  logic div_done;
  logic unit_done;

  // Divider control to datapath
  logic div_load;
  logic div_step;
  logic div_by_zero;

  // Stage handshake
  logic ex_valid;
  logic accept;

  assign md_op     = id_ex_i.op.md;
  assign mul_start = id_ex_i.valid && (id_ex_i.unit == ex_pkg::unit_mul);
  assign div_start = id_ex_i.valid && (id_ex_i.unit == ex_pkg::unit_div);

  // ALU and unknown units finish at once
  always_comb begin
    case (id_ex_i.unit)
      ex_pkg::unit_mul: unit_done = mul_done;
      ex_pkg::unit_div: unit_done = div_done;
      default:          unit_done = 1'b1;
    endcase
  end

  assign ex_valid   = id_ex_i.valid && unit_done;
  // Empty stage is ready as soon as WB is
  assign ex_ready_o = id_ex_i.valid ? (ex_valid && wb_ready_i) : wb_ready_i;
  assign accept     = id_ex_i.valid && ex_ready_o;

  //////////////////////////////////////////////////////////////////////
  // Units
  //////////////////////////////////////////////////////////////////////

  ex_alu alu0 (
    .op_i     (id_ex_i.op.alu),
    .a_i      (id_ex_i.op_a),
    .b_i      (id_ex_i.op_b),
    .result_o (alu_result)
  );

  ex_mult mult0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (mul_start),
    .op_i     (md_op),
    .a_i      (id_ex_i.op_a),
    .b_i      (id_ex_i.op_b),
    .accept_i (accept),
    .done_o   (mul_done),
    .result_o (mul_result)
  );

  div_ctrl_fsm div_fsm0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (div_start),
    .div_by_zero_i (div_by_zero),
    .accept_i      (accept),
    .load_o        (div_load),
    .step_o        (div_step),
    .done_o        (div_done)
  );

  div_datapath div_dp0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_i        (div_load),
    .step_i        (div_step),
    .op_i          (md_op),
    .a_i           (id_ex_i.op_a),
    .b_i           (id_ex_i.op_b),
    .div_by_zero_o (div_by_zero),
    .result_o      (div_result)
  );

  // Pipeline register towards WB
  ex_wb_reg wb_reg0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_ex_i      (id_ex_i),
    .finish_i     (ex_valid),
    .wb_ready_i   (wb_ready_i),
    .alu_result_i (alu_result),
    .mul_result_i (mul_result),
    .div_result_i (div_result),
    .ex_wb_o      (ex_wb_o)
  );

endmodule

// ==== ex_stage_props.sv ====
// Bound into ex_stage; all properties are off while rst_n is low
`timescale 1ns/100ps

module ex_stage_props (
  input logic           clk,
  input logic           rst_n,
  input ex_pkg::id_ex_t id_ex_i,
  input logic           wb_ready_i,
  input logic           ex_ready_i,
  input ex_pkg::ex_wb_t ex_wb_i
);

  // Set at the first accepted instruction
  logic seen_accept_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_accept_q <= 1'b0;
    end else if (id_ex_i.valid && ex_ready_i) begin
      seen_accept_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake properties
  //////////////////////////////////////////////////////////////////////

  a_no_early_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_accept_q |-> !ex_wb_i.valid)
    else $error("WB valid before the first accepted instruction");

  // Register holds across a stalled edge
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(ex_wb_i))
    else $error("EX/WB word changed while WB was stalled");

  // A ready edge loads a word exactly when an instruction was accepted there
  a_valid_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ready_i |=> (ex_wb_i.valid == $past(id_ex_i.valid && ex_ready_i)))
    else $error("EX/WB valid does not match the acceptance at the previous edge");

  // Decode side of the handshake
  a_input_held: assert property (@(posedge clk) disable iff (!rst_n)
    (id_ex_i.valid && !ex_ready_i) |=> $stable(id_ex_i))
    else $error("Decode changed a pending instruction");

endmodule

bind ex_stage ex_stage_props props0 (
  .clk        (clk),
  .rst_n      (rst_n),
  .id_ex_i    (id_ex_i),
  .wb_ready_i (wb_ready_i),
  .ex_ready_i (ex_ready_o),
  .ex_wb_i    (ex_wb_o)
);

// ==== ex_checker.sv ====
// Samples on the falling edge, when decode and DUT outputs are settled for the next rising edge
`timescale 1ns/100ps

module ex_checker (
  input  logic           clk,
  input  logic           rst_n,
  input  ex_pkg::id_ex_t id_ex_i,
  input  logic           ex_ready_i,
  input  ex_pkg::ex_wb_t ex_wb_i,
  input  logic           wb_ready_i,
  output int unsigned    checks_o,
  output int unsigned    errors_o,
  output int unsigned    pending_o
);

  // Expected WB words in acceptance order
  ex_pkg::ex_wb_t exp_q[$];
  ex_pkg::ex_wb_t head;
  ex_pkg::ex_wb_t fresh;
  logic           seen_accept;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] model_result(input ex_pkg::id_ex_t ins);
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] a64;
    logic [63:0] b64;
    logic [63:0] prod;
    logic        is_rem;
    logic        is_signed;
    int          sa;
    int          sb;
    a         = ins.op_a;
    b         = ins.op_b;
    sa        = a;
    sb        = b;
    is_rem    = (ins.op.md == ex_pkg::md_rem) || (ins.op.md == ex_pkg::md_remu);
    is_signed = (ins.op.md == ex_pkg::md_div) || (ins.op.md == ex_pkg::md_rem);
    case (ins.unit)
      ex_pkg::unit_mul: begin
        // Low 64 bits of the product of 64-bit extensions are exact for every sign mix
        a64  = {{32{a[31] && (ins.op.md == ex_pkg::md_mulh ||
                               ins.op.md == ex_pkg::md_mulhsu)}}, a};
        b64  = {{32{b[31] && (ins.op.md == ex_pkg::md_mulh)}}, b};
        prod = a64 * b64;
        return (ins.op.md == ex_pkg::md_mul) ? prod[31:0] : prod[63:32];
      end
      ex_pkg::unit_div: begin
        if (b == 32'h0) return is_rem ? a : 32'hffff_ffff;
        // Signed overflow
        if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) return is_rem ? 32'h0 : a;
        case (ins.op.md)
          ex_pkg::md_div:  return sa / sb;
          ex_pkg::md_rem:  return sa % sb;
          ex_pkg::md_divu: return a / b;
          default:         return a % b;
        endcase
      end
      default: begin
        case (ins.op.alu)
          ex_pkg::alu_add:  return a + b;
          ex_pkg::alu_sub:  return a + ~b + 32'd1;
          ex_pkg::alu_and:  return a & b;
          ex_pkg::alu_or:   return a | b;
          ex_pkg::alu_xor:  return a ^ b;
          ex_pkg::alu_sll:  return a << b[4:0];
          ex_pkg::alu_srl:  return a >> b[4:0];
          // Logical shift, then fill the vacated top bits with the sign
          ex_pkg::alu_sra:  return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
          ex_pkg::alu_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
          ex_pkg::alu_sltu: return {31'b0, a < b};
          default:          return 32'h0;
        endcase
      end
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Write-back stream compare
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      // Nothing may come out before the first instruction goes in
      if (!seen_accept) begin
        checks_o++;
        if (ex_wb_i.valid) begin
          errors_o++;
          $display("Error %0d ns: valid word on WB before any instruction was accepted", $time);
        end
      end
      // WB takes the current word at the coming edge
      if (ex_wb_i.valid && wb_ready_i) begin
        if (exp_q.size() == 0) begin
          errors_o++;
          $display("Error %0d ns: WB word for rd %0d with no instruction outstanding",
                   $time, ex_wb_i.rd);
        end else begin
          head = exp_q.pop_front();
          checks_o++;
          if (ex_wb_i.rd != head.rd || ex_wb_i.rf_we != head.rf_we ||
              ex_wb_i.wdata != head.wdata) begin
            errors_o++;
            $display("Error %0d ns: rd %0d we %0b wdata %08h, expected rd %0d we %0b wdata %08h",
                     $time, ex_wb_i.rd, ex_wb_i.rf_we, ex_wb_i.wdata,
                     head.rd, head.rf_we, head.wdata);
          end
        end
      end
      // EX takes the presented instruction at the coming edge
      if (id_ex_i.valid && ex_ready_i) begin
        fresh.valid = 1'b1;
        fresh.rd    = id_ex_i.rd;
        fresh.rf_we = id_ex_i.rf_we;
        fresh.wdata = model_result(id_ex_i);
        exp_q.push_back(fresh);
        seen_accept = 1'b1;
      end
      pending_o = exp_q.size();
    end
  end

  initial begin
    seen_accept = 1'b0;
    checks_o    = 0;
    errors_o    = 0;
    pending_o   = 0;
  end

endmodule

// ==== tb_ex_stage.sv ====
// Random stream from LCG seed 82; inputs move only on rising edges and every wait gives up
`timescale 1ns/100ps

module tb_ex_stage;

  // Run length and wait limits in clock cycles
  localparam int unsigned n_alu       = 200;
  localparam int unsigned n_mul       = 100;
  localparam int unsigned n_div       = 100;
  localparam int unsigned n_mix       = 200;
  localparam int unsigned accept_wait = 200;
  localparam int unsigned drain_wait  = 400;

  logic           clk;
  logic           rst_n;
  ex_pkg::id_ex_t id_ex;
  logic           wb_ready;
  logic           ex_ready;
  ex_pkg::ex_wb_t ex_wb;

  // Counters kept by the checker
  int unsigned checks;
  int unsigned errors;
  int unsigned pending;

  // Per-test bookkeeping
  int unsigned timeouts;
  int unsigned mark_checks;
  int unsigned mark_fails;

  logic [31:0] lcg_state;

  always #10 clk = ~clk;

  ex_stage dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .id_ex_i    (id_ex),
    .wb_ready_i (wb_ready),
    .ex_ready_o (ex_ready),
    .ex_wb_o    (ex_wb)
  );

  ex_checker chk0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .id_ex_i    (id_ex),
    .ex_ready_i (ex_ready),
    .ex_wb_i    (ex_wb),
    .wb_ready_i (wb_ready),
    .checks_o   (checks),
    .errors_o   (errors),
    .pending_o  (pending)
  );

  //////////////////////////////////////////////////////////////////////
  // Random numbers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Low LCG bits are weak, so only the upper halves are used
  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  // Corner values show up about half the time
  function automatic logic [31:0] rand_operand();
    logic [31:0] sel;
    sel = lcg_next();
    case (sel[31:29])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'hffff_ffff;
      3'd2:    return 32'h8000_0000;
      3'd3:    return {27'b0, sel[28:24]};
      default: return rand_word();
    endcase
  endfunction

  // WB stalls about one cycle in four
  function automatic logic ready_draw();
    logic [31:0] r;
    r = lcg_next();
    return r[31:30] != 2'b00;
  endfunction

  function automatic ex_pkg::id_ex_t make_ins(input ex_pkg::ex_unit_e unit);
    ex_pkg::id_ex_t ins;
    logic [31:0]    r;
    r         = lcg_next();
    ins.valid = 1'b1;
    ins.unit  = unit;
    ins.rd    = r[31:27];
    ins.rf_we = r[26] | r[25];
    case (unit)
      ex_pkg::unit_mul: ins.op.md = ex_pkg::md_op_e'({2'b00, r[24:23]});
      ex_pkg::unit_div: ins.op.md = ex_pkg::md_op_e'({2'b01, r[24:23]});
      default:          ins.op.alu = ex_pkg::alu_op_e'(4'(r[24:16] % 10));
    endcase
    ins.op_a = rand_operand();
    ins.op_b = rand_operand();
    return ins;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Handshake tasks
  //////////////////////////////////////////////////////////////////////

  // Present one instruction and hold it until EX takes it
  // Ready is looked at on the falling edge, where it is settled for the next rising edge
  task automatic send(input ex_pkg::id_ex_t ins);
    int unsigned waited;
    waited = 0;
    id_ex    <= ins;
    wb_ready <= ready_draw();
    @(negedge clk);
    while (!ex_ready && waited < accept_wait) begin
      @(posedge clk);
      wb_ready <= ready_draw();
      waited++;
      @(negedge clk);
    end
    if (!ex_ready) begin
      timeouts++;
      $display("Timeout: EX did not accept the instruction for rd %0d", ins.rd);
    end
    @(posedge clk);
  endtask

  // Idle decode until every accepted instruction has reached WB
  task automatic drain();
    int unsigned waited;
    waited = 0;
    id_ex <= '0;
    while (pending != 0 && waited < drain_wait) begin
      wb_ready <= ready_draw();
      waited++;
      @(posedge clk);
    end
    if (pending != 0) begin
      timeouts++;
      $display("Timeout: %0d accepted instructions never reached write-back", pending);
    end
  endtask

  task automatic close_test(input int unsigned num, input string name);
    int unsigned n_chk;
    int unsigned n_bad;
    drain();
    n_chk = checks - mark_checks;
    n_bad = errors + timeouts - mark_fails;
    $display("test %0d %s %0d checks, %0d errors: %s", num, name, n_chk, n_bad,
             (n_bad == 0) ? "ok" : "bad");
    mark_checks = checks;
    mark_fails  = errors + timeouts;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    ex_pkg::id_ex_t ins;
    clk         = 1'b0;
    rst_n       = 1'b0;
    id_ex       = '0;
    wb_ready    = 1'b0;
    lcg_state   = 32'd82;
    timeouts    = 0;
    mark_checks = 0;
    mark_fails  = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Empty pipe right after reset
    repeat (8) begin
      wb_ready <= ready_draw();
      @(posedge clk);
    end
    close_test(1, "reset");

    for (int i = 0; i < n_alu; i++) send(make_ins(ex_pkg::unit_alu));
    close_test(2, "alu");

    for (int i = 0; i < n_mul; i++) send(make_ins(ex_pkg::unit_mul));
    close_test(3, "mul");

    // Zero divisor for all four ops, then most negative over minus one
    for (int k = 0; k < 8; k++) begin
      ins       = make_ins(ex_pkg::unit_div);
      ins.op.md = ex_pkg::md_op_e'(4'(4 + k % 4));
      ins.op_a  = (k < 4) ? rand_word() : 32'h8000_0000;
      ins.op_b  = (k < 4) ? 32'h0000_0000 : 32'hffff_ffff;
      send(ins);
    end
    for (int i = 0; i < n_div; i++) send(make_ins(ex_pkg::unit_div));
    close_test(4, "div");

    for (int i = 0; i < n_mix; i++) begin
      send(make_ins(ex_pkg::ex_unit_e'(2'(lcg_next() % 3))));
    end
    close_test(5, "mixed");

    $display("total: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
ex_pkg.sv
ex_alu.sv
ex_mult.sv
div_ctrl_fsm.sv
div_datapath.sv
ex_wb_reg.sv
ex_stage.sv
ex_stage_props.sv
ex_checker.sv
tb_ex_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator and run it; exit status 0 means pass

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_ex_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ex_stage > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$log"; then
  echo "simulation reported failures"
  exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$log"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
